// File: Bender.yml
package:
  name: maze_video

sources:
  - files:
      - logic/maze_pkg.sv
      - logic/level_map.sv
      - logic/rect_hit.sv
      - logic/pixel_shader.sv
      - logic/player_ctrl.sv
      - logic/game_fsm.sv
      - logic/maze_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/maze_tb.sv

// File: logic/game_fsm.sv
`timescale 1ns/10ps

module game_fsm (
	input logic clk,
	input logic rst_n,
	input maze_pkg::level_t level_select,
	input logic level_lock,
	output maze_pkg::game_state_t state,
	output maze_pkg::level_t level
);
	import maze_pkg::*;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (level_select != LVL_NONE)
					begin
						state <= ST_SELECT;
					end
				end
				ST_SELECT:
				begin
					if (level_lock)
					begin
						state <= ST_PLAY;
					end
				end
				ST_PLAY:
				begin
					if (!level_lock)
					begin
						state <= ST_SELECT;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// level frozen outside select
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			level <= LVL_NONE;
		end
		else if (state == ST_SELECT)
		begin
			level <= level_select;
		end
	end

endmodule

// File: logic/level_map.sv
`timescale 1ns/10ps

module level_map (
	input maze_pkg::level_t level,
	output maze_pkg::rect_t slots [maze_pkg::NUM_SLOTS]
);
	import maze_pkg::*;

	always_comb
	begin
		case (level)
			LVL_1:
			begin
				slots = LEVEL1_SLOTS;
			end
			LVL_2:
			begin
				slots = LEVEL2_SLOTS;
			end
			LVL_3:
			begin
				slots = LEVEL3_SLOTS;
			end
			default:
			begin
				// nothing drawn before a level is picked
				slots = NO_SLOTS;
			end
		endcase
	end

endmodule

// File: logic/maze_pkg.sv
package maze_pkg;

	localparam int COL_W = 10;
	localparam int ROW_W = 9;
	localparam int NUM_SLOTS = 13;
	localparam int PLAYER_SIZE = 25;
	localparam int STEP = 5;

	typedef struct packed {
		logic [COL_W-1:0] col;
		logic [ROW_W-1:0] row;
	} pixel_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	typedef enum logic [1:0] {LVL_NONE, LVL_1, LVL_2, LVL_3} level_t;

	typedef enum logic [1:0] {ST_IDLE, ST_SELECT, ST_PLAY} game_state_t;

	typedef enum logic [1:0] {SLOT_EMPTY, SLOT_START, SLOT_FINISH, SLOT_PATH} slot_kind_t;

	typedef struct packed {
		slot_kind_t kind;
		logic [COL_W-1:0] x;
		logic [ROW_W-1:0] y;
		logic [COL_W-1:0] w;
		logic [ROW_W-1:0] h;
	} rect_t;

	// switch order as on the board, left is the top bit
	typedef struct packed {
		logic left;
		logic up;
		logic down;
		logic right;
	} dir_t;

	localparam rgb_t COLOR_BLACK = '{r: 4'h0, g: 4'h0, b: 4'h0};
	localparam rgb_t COLOR_GREEN = '{r: 4'h0, g: 4'hf, b: 4'h0};
	localparam rgb_t COLOR_RED = '{r: 4'hf, g: 4'h0, b: 4'h0};
	localparam rgb_t COLOR_WHITE = '{r: 4'hf, g: 4'hf, b: 4'hf};
	localparam rgb_t COLOR_MAGENTA = '{r: 4'hf, g: 4'h0, b: 4'hf};

	localparam rect_t EMPTY_RECT = '{SLOT_EMPTY, 0, 0, 0, 0};

	// slot 0 start, slot 1 finish, then path
	localparam rect_t NO_SLOTS [NUM_SLOTS] = '{default: EMPTY_RECT};

	localparam rect_t LEVEL1_SLOTS [NUM_SLOTS] = '{
		0: '{SLOT_START, 100, 430, 50, 50},
		1: '{SLOT_FINISH, 500, 0, 140, 50},
		2: '{SLOT_PATH, 100, 100, 50, 380},
		3: '{SLOT_PATH, 150, 100, 150, 50},
		4: '{SLOT_PATH, 300, 100, 50, 380},
		5: '{SLOT_PATH, 350, 350, 150, 130},
		6: '{SLOT_PATH, 500, 0, 140, 480},
		default: EMPTY_RECT
	};

	localparam rect_t LEVEL2_SLOTS [NUM_SLOTS] = '{
		'{SLOT_START, 20, 430, 50, 50},
		'{SLOT_FINISH, 590, 430, 50, 50},
		'{SLOT_PATH, 20, 100, 50, 380},
		'{SLOT_PATH, 20, 50, 130, 50},
		'{SLOT_PATH, 100, 100, 50, 350},
		'{SLOT_PATH, 120, 400, 430, 50},
		'{SLOT_PATH, 500, 100, 50, 300},
		'{SLOT_PATH, 370, 100, 130, 50},
		'{SLOT_PATH, 320, 100, 50, 170},
		'{SLOT_PATH, 190, 220, 130, 50},
		'{SLOT_PATH, 190, 30, 50, 190},
		'{SLOT_PATH, 190, 30, 450, 50},
		'{SLOT_PATH, 590, 55, 50, 425}
	};

	localparam rect_t LEVEL3_SLOTS [NUM_SLOTS] = '{
		0: '{SLOT_START, 0, 90, 50, 300},
		1: '{SLOT_FINISH, 570, 220, 50, 35},
		2: '{SLOT_PATH, 0, 90, 160, 300},
		3: '{SLOT_PATH, 160, 140, 120, 200},
		4: '{SLOT_PATH, 280, 190, 120, 100},
		5: '{SLOT_PATH, 400, 220, 220, 35},
		default: EMPTY_RECT
	};

	localparam pixel_t START_L1 = '{col: 113, row: 443};
	localparam pixel_t START_L2 = '{col: 33, row: 443};
	localparam pixel_t START_L3 = '{col: 13, row: 230};

	// no level falls back to level one
	function automatic pixel_t start_pos(level_t lvl);
		case (lvl)
			LVL_2: return START_L2;
			LVL_3: return START_L3;
			default: return START_L1;
		endcase
	endfunction

	function automatic logic rect_contains(rect_t r, pixel_t p);
		logic [COL_W:0] x_end;
		logic [ROW_W:0] y_end;
		x_end = {1'b0, r.x} + {1'b0, r.w};
		y_end = {1'b0, r.y} + {1'b0, r.h};
		return (r.kind != SLOT_EMPTY) && (p.col >= r.x) && ({1'b0, p.col} < x_end)
			&& (p.row >= r.y) && ({1'b0, p.row} < y_end);
	endfunction

	// player square with its top-left corner at p
	function automatic logic rect_overlap(rect_t r, pixel_t p);
		logic [COL_W:0] x_end;
		logic [ROW_W:0] y_end;
		logic [COL_W:0] p_x_end;
		logic [ROW_W:0] p_y_end;
		x_end = {1'b0, r.x} + {1'b0, r.w};
		y_end = {1'b0, r.y} + {1'b0, r.h};
		p_x_end = {1'b0, p.col} + (COL_W+1)'(PLAYER_SIZE);
		p_y_end = {1'b0, p.row} + (ROW_W+1)'(PLAYER_SIZE);
		return (r.kind != SLOT_EMPTY) && ({1'b0, p.col} < x_end) && (p_x_end > {1'b0, r.x})
			&& ({1'b0, p.row} < y_end) && (p_y_end > {1'b0, r.y});
	endfunction

endpackage

// File: logic/maze_top.sv
`timescale 1ns/10ps

module maze_top (
	input logic clk,
	input logic rst_n,
	input maze_pkg::pixel_t pixel,
	input maze_pkg::level_t level_select,
	input logic level_lock,
	input logic key_n,
	input maze_pkg::dir_t switches,
	output maze_pkg::rgb_t rgb
);
	import maze_pkg::*;

	game_state_t state;
	level_t level;
	rect_t slots [NUM_SLOTS];
	slot_kind_t kinds [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] hits;
	pixel_t player;

	game_fsm fsm_i (
		.clk(clk),
		.rst_n(rst_n),
		.level_select(level_select),
		.level_lock(level_lock),
		.state(state),
		.level(level)
	);

	level_map map_i (
		.level(level),
		.slots(slots)
	);

	// one hit test per rectangle slot
	for (genvar i = 0; i < NUM_SLOTS; i++)
	begin : g_slot
		assign kinds[i] = slots[i].kind;

		rect_hit hit_i (
			.clk(clk),
			.rst_n(rst_n),
			.slot(slots[i]),
			.pixel(pixel),
			.hit(hits[i])
		);
	end

	pixel_shader shader_i (
		.clk(clk),
		.rst_n(rst_n),
		.pixel(pixel),
		.hits(hits),
		.kinds(kinds),
		.state(state),
		.player(player),
		.rgb(rgb)
	);

	player_ctrl player_i (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.level(level),
		.slots(slots),
		.switches(switches),
		.key_n(key_n),
		.pixel(pixel),
		.player(player)
	);

endmodule

// File: logic/pixel_shader.sv
`timescale 1ns/10ps

module pixel_shader (
	input logic clk,
	input logic rst_n,
	input maze_pkg::pixel_t pixel,
	input logic [maze_pkg::NUM_SLOTS-1:0] hits,
	input maze_pkg::slot_kind_t kinds [maze_pkg::NUM_SLOTS],
	input maze_pkg::game_state_t state,
	input maze_pkg::pixel_t player,
	output maze_pkg::rgb_t rgb
);
	import maze_pkg::*;

	pixel_t pix_q;
	slot_kind_t kinds_q [NUM_SLOTS];
	slot_kind_t hit_kind;
	logic in_player;
	logic no_level;
	rgb_t color;

	// line up with the registered hit bits
	always_ff @(posedge clk)
	begin
		pix_q <= pixel;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			kinds_q <= '{default: SLOT_EMPTY};
			rgb <= COLOR_BLACK;
		end
		else
		begin
			kinds_q <= kinds;
			rgb <= color;
		end
	end

	always_comb
	begin
		in_player = (pix_q.col >= player.col)
			&& ({1'b0, pix_q.col} < {1'b0, player.col} + (COL_W+1)'(PLAYER_SIZE))
			&& (pix_q.row >= player.row)
			&& ({1'b0, pix_q.row} < {1'b0, player.row} + (ROW_W+1)'(PLAYER_SIZE));

		// slot 0 is the start square of every loaded level
		no_level = (kinds_q[0] == SLOT_EMPTY);

		// lowest slot wins
		hit_kind = SLOT_EMPTY;
		for (int i = NUM_SLOTS - 1; i >= 0; i--)
		begin
			if (hits[i])
			begin
				hit_kind = kinds_q[i];
			end
		end

		if (state == ST_IDLE || no_level)
		begin
			color = COLOR_BLACK;
		end
		else if (in_player)
		begin
			color = COLOR_MAGENTA;
		end
		else
		begin
			case (hit_kind)
				SLOT_START: color = COLOR_GREEN;
				SLOT_FINISH: color = COLOR_RED;
				SLOT_PATH: color = COLOR_WHITE;
				default: color = COLOR_BLACK;
			endcase
		end
	end

endmodule

// File: logic/player_ctrl.sv
`timescale 1ns/10ps

module player_ctrl (
	input logic clk,
	input logic rst_n,
	input maze_pkg::game_state_t state,
	input maze_pkg::level_t level,
	input maze_pkg::rect_t slots [maze_pkg::NUM_SLOTS],
	input maze_pkg::dir_t switches,
	input logic key_n,
	input maze_pkg::pixel_t pixel,
	output maze_pkg::pixel_t player
);
	import maze_pkg::*;

	pixel_t start;
	pixel_t next_pos;
	logic frame_start;
	logic on_path;
	logic at_finish;
	logic finished;

	always_comb
	begin
		start = start_pos(level);
		frame_start = (pixel.col == '0) && (pixel.row == '0);

		// first set switch wins
		next_pos = player;
		if (switches.left)
		begin
			next_pos.col = player.col - COL_W'(STEP);
		end
		else if (switches.up)
		begin
			next_pos.row = player.row - ROW_W'(STEP);
		end
		else if (switches.down)
		begin
			next_pos.row = player.row + ROW_W'(STEP);
		end
		else if (switches.right)
		begin
			next_pos.col = player.col + COL_W'(STEP);
		end

		on_path = 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			if (rect_overlap(slots[i], next_pos))
			begin
				on_path = 1'b1;
			end
		end

		// corner test against the finish slot
		at_finish = rect_contains(slots[1], next_pos);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			player <= START_L1;
			finished <= 1'b0;
		end
		else if (state != ST_PLAY)
		begin
			player <= start;
			finished <= 1'b0;
		end
		else if (finished)
		begin
			if (!key_n)
			begin
				player <= start;
				finished <= 1'b0;
			end
		end
		else if (frame_start)
		begin
			if (!on_path)
			begin
				// fell off the maze, back to start
				player <= start;
			end
			else
			begin
				player <= next_pos;
				finished <= at_finish;
			end
		end
	end

endmodule

// File: logic/rect_hit.sv
`timescale 1ns/10ps

module rect_hit (
	input logic clk,
	input logic rst_n,
	input maze_pkg::rect_t slot,
	input maze_pkg::pixel_t pixel,
	output logic hit
);
	import maze_pkg::*;

	// empty slots never hit, handled in rect_contains
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hit <= 1'b0;
		end
		else
		begin
			hit <= rect_contains(slot, pixel);
		end
	end

endmodule

// File: sim/maze_patterns.txt
# rep (decimal) col row level_select level_lock key_n switches probe rgb, all but rep in hex
# probe 0 = none, 1 = compare rgb, 2 = black while idle; switches bits are left up down right
1 078 1c2 0 0 1 0 2 000
1 000 000 0 0 1 0 2 000
1 1f4 010 0 0 1 0 2 000
# level one in select
2 001 001 1 0 1 0 0 000
1 064 1ae 1 0 1 0 1 0f0
1 071 1bb 1 0 1 0 1 f0f
1 226 014 1 0 1 0 1 f00
1 078 0c8 1 0 1 0 1 fff
1 032 032 1 0 1 0 1 000
# level two in select
2 001 001 2 0 1 0 0 000
1 014 1ae 2 0 1 0 1 0f0
1 021 1bb 2 0 1 0 1 f0f
1 258 1c2 2 0 1 0 1 f00
1 078 1a4 2 0 1 0 1 fff
1 12c 15e 2 0 1 0 1 000
# level three in select
2 001 001 3 0 1 0 0 000
1 000 064 3 0 1 0 1 0f0
1 00d 0e6 3 0 1 0 1 f0f
1 244 0e6 3 0 1 0 1 f00
1 0c8 0c8 3 0 1 0 1 fff
1 1f4 064 3 0 1 0 1 000
# level one play, one step right
3 001 001 1 0 1 0 0 000
2 001 001 1 1 1 0 0 000
1 071 1bb 1 1 1 0 1 f0f
1 000 000 1 1 1 1 0 000
1 071 1bb 1 1 1 0 1 0f0
1 08e 1bb 1 1 1 0 1 f0f
1 08f 1bb 1 1 1 0 1 0f0
# left to the edge of the start square, then off it
8 000 000 1 1 1 8 0 000
1 04e 1bb 1 1 1 0 1 f0f
1 04d 1bb 1 1 1 0 1 000
1 000 000 1 1 1 8 0 000
1 071 1bb 1 1 1 0 1 f0f
1 04e 1bb 1 1 1 0 1 000
# level three play, right until the finish
3 001 001 3 0 1 0 0 000
2 001 001 3 1 1 0 0 000
1 00d 0e6 3 1 1 0 1 f0f
112 000 000 3 1 1 1 0 000
3 000 000 3 1 1 1 0 000
1 23d 0e6 3 1 1 1 1 f0f
1 23c 0e6 3 1 1 1 1 f00
1 255 0e6 3 1 1 1 1 f0f
1 256 0e6 3 1 1 1 1 f00
# key press restarts
1 001 001 3 1 0 0 0 000
1 00d 0e6 3 1 1 0 1 f0f
1 23d 0e6 3 1 1 0 1 f00
# two steps, then back to select
2 000 000 3 1 1 1 0 000
1 026 0e6 3 1 1 0 1 f0f
2 001 001 3 0 1 0 0 000
1 00d 0e6 3 0 1 0 1 f0f
1 026 0e6 3 0 1 0 1 0f0

// File: sim/maze_checks.svh
`ifndef MAZE_CHECKS_SVH
`define MAZE_CHECKS_SVH

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_rgb(input rgb_t expected, input rgb_t actual, input string name);
		if (actual !== expected)
		begin
			abort_run($sformatf("FAILED at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual));
		end
	endtask

	// idle screen is black everywhere
	task automatic expect_idle_black(input rgb_t actual);
		rgb_t black;
		black = '{r: 4'h0, g: 4'h0, b: 4'h0};
		if (actual !== black)
		begin
			abort_run($sformatf("FAILED at %0t ns: rgb expected %h while idle, got %h",
				$time, black, actual));
		end
	endtask

`endif

// File: sim/maze_tb.sv
`timescale 1ns/10ps

module maze_tb;
	import maze_pkg::*;

	// one cycle of stimulus plus what rgb should show for it
	typedef struct packed {
		pixel_t pixel;
		level_t level_select;
		logic level_lock;
		logic key_n;
		dir_t switches;
		logic [1:0] probe;
		rgb_t expected;
	} vector_t;

	localparam string PATTERN_FILE = "sim/maze_patterns.txt";

	logic clk;
	logic rst_n;
	pixel_t pixel;
	level_t level_select;
	logic level_lock;
	logic key_n;
	dir_t switches;
	rgb_t rgb;

	vector_t vectors [$];
	int checks_planned = 0;
	int checks_done = 0;
	int cycle_limit = 0;
	int cycle_count = 0;

	`include "maze_checks.svh"

	maze_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.pixel(pixel),
		.level_select(level_select),
		.level_lock(level_lock),
		.key_n(key_n),
		.switches(switches),
		.rgb(rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = ~clk;
		end
	end

	// armed once the pattern count is known
	always @(posedge clk)
	begin
		if (cycle_limit > 0)
		begin
			cycle_count = cycle_count + 1;
			if (cycle_count > cycle_limit)
			begin
				abort_run($sformatf("timeout: run still going after %0d cycles", cycle_limit));
			end
		end
	end

	task automatic load_patterns();
		int fd;
		int line_no;
		int fields;
		int f [9];
		string line;
		vector_t v;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
		begin
			abort_run({"cannot open the pattern file ", PATTERN_FILE});
		end
		line_no = 0;
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			line_no++;
			if (line.len() < 2 || line[0] == "#")
			begin
				continue;
			end
			fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
			if (fields != 9 || f[0] < 1 || f[7] > 2)
			begin
				abort_run($sformatf("pattern file line %0d is malformed", line_no));
			end
			v.pixel.col = f[1][COL_W-1:0];
			v.pixel.row = f[2][ROW_W-1:0];
			v.level_select = level_t'(f[3][1:0]);
			v.level_lock = f[4][0];
			v.key_n = f[5][0];
			v.switches = dir_t'(f[6][3:0]);
			v.probe = f[7][1:0];
			v.expected = rgb_t'(f[8][11:0]);
			// a repeat count expands into one vector per cycle
			for (int k = 0; k < f[0]; k++)
			begin
				vectors.push_back(v);
				if (v.probe != 2'd0)
				begin
					checks_planned++;
				end
			end
		end
		$fclose(fd);
		if (vectors.size() == 0)
		begin
			abort_run("the pattern file holds no vectors");
		end
	endtask

	task automatic apply_vector(input vector_t v);
		pixel <= v.pixel;
		level_select <= v.level_select;
		level_lock <= v.level_lock;
		key_n <= v.key_n;
		switches <= v.switches;
	endtask

	task automatic check_vector(input vector_t v);
		if (v.probe == 2'd1)
		begin
			compare_rgb(v.expected, rgb, "rgb");
			checks_done++;
		end
		else if (v.probe == 2'd2)
		begin
			expect_idle_black(rgb);
			checks_done++;
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		pixel = '0;
		level_select = LVL_NONE;
		level_lock = 1'b0;
		key_n = 1'b1;
		switches = '0;
		load_patterns();
		cycle_limit = vectors.size() + 20;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		// rgb for vector i is stable in the low phase two cycles later
		for (int i = 0; i < vectors.size() + 2; i++)
		begin
			@(posedge clk);
			if (i < vectors.size())
			begin
				apply_vector(vectors[i]);
			end
			@(negedge clk);
			if (i >= 2)
			begin
				check_vector(vectors[i - 2]);
			end
		end
		if (checks_done == checks_planned && checks_done > 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			abort_run($sformatf("only %0d of %0d probes were checked", checks_done,
				checks_planned));
		end
	end

endmodule

// File: src.f
+incdir+sim
logic/maze_pkg.sv
logic/level_map.sv
logic/rect_hit.sv
logic/pixel_shader.sv
logic/player_ctrl.sv
logic/game_fsm.sv
logic/maze_top.sv
sim/maze_tb.sv
